//--- common/camera_cfg_pkg.sv
`default_nettype none

package camera_cfg_pkg;

    localparam logic [7:0] CAMERA_ADDR = 8'h42;  // OV7670 write address

    localparam int CFG_SIZE = 22;
    localparam int CFG_INDEX_W = 5;
    localparam logic [CFG_INDEX_W-1:0] CFG_END = CFG_INDEX_W'(CFG_SIZE);  // Index past the table

    // One register write
    typedef struct packed {
        logic [7:0] reg_addr;
        logic [7:0] reg_data;
    } cfg_entry_t;

    // RGB444 setup, written in this order
    localparam cfg_entry_t CFG_TABLE [CFG_SIZE] = '{
        '{8'h12, 8'h80},  // COM7 soft reset
        '{8'h11, 8'h00},  // No input clock prescale
        '{8'h3A, 8'h04},  // TSLB output sequence
        '{8'h12, 8'h04},  // COM7 selects RGB
        '{8'h8C, 8'h02},  // RGB444 on
        '{8'h40, 8'hD0},  // COM15 full range, RGB444 word
        '{8'h14, 8'h1A},  // Gain ceiling
        '{8'h4F, 8'hB3},  // Matrix coefficient 1
        '{8'h50, 8'hB3},  // Matrix coefficient 2
        '{8'h51, 8'h00},  // Matrix coefficient 3
        '{8'h52, 8'h3D},  // Matrix coefficient 4
        '{8'h53, 8'hA7},  // Matrix coefficient 5
        '{8'h54, 8'hE4},  // Matrix coefficient 6
        '{8'h3D, 8'hC3},  // COM13 gamma and UV
        '{8'h17, 8'h11},  // Horizontal start
        '{8'h18, 8'h75},  // Horizontal stop
        '{8'h19, 8'h02},  // Vertical start
        '{8'h1A, 8'hA2},  // Vertical stop
        '{8'h32, 8'h80},  // HREF edge offsets
        '{8'h03, 8'h0A},  // VREF low bits
        '{8'h0C, 8'h00},  // COM3 scaling off
        '{8'h3E, 8'h00}   // COM14 no PCLK divide
    };

endpackage

`default_nettype wire

//--- common/sccb_pkg.sv
`default_nettype none

package sccb_pkg;

    // Master FSM states, one per bus phase
    typedef enum logic [2:0] {
        SCCB_IDLE,       // Bus released, waiting for a write
        SCCB_START,      // SIOD falls while SIOC is high
        SCCB_SEND_BYTE,  // Eight data bits, MSB first
        SCCB_ACK,        // Ninth bit, SIOD released
        SCCB_STOP,       // SIOD rises while SIOC is high
        SCCB_GAP         // Quiet time before the next start
    } sccb_state_t;

    // SIOC timing in system clocks
    localparam int SCCB_HALF_PERIOD = 8;
    localparam int SCCB_TICK_W = $clog2(SCCB_HALF_PERIOD);
    localparam logic [SCCB_TICK_W-1:0] SCCB_TICK_LAST = SCCB_TICK_W'(SCCB_HALF_PERIOD - 1);

    // Bus idle time after each stop condition
    localparam int SCCB_GAP_CYCLES = 64;
    localparam int SCCB_GAP_W = $clog2(SCCB_GAP_CYCLES);
    localparam logic [SCCB_GAP_W-1:0] SCCB_GAP_LAST = SCCB_GAP_W'(SCCB_GAP_CYCLES - 1);

    // Device address, register, data
    localparam int SCCB_BYTES_PER_WRITE = 3;
    localparam logic [1:0] SCCB_LAST_BYTE = 2'(SCCB_BYTES_PER_WRITE - 1);

endpackage

`default_nettype wire

//--- project.f
common/sccb_pkg.sv
common/camera_cfg_pkg.sv
verilog/cfg_table_sequencer.sv
verilog/write_fifo.sv
sccb_master/sccb_master.sv
verilog/camera_config_top.sv
verification/clock_gen.sv
verification/sccb_camera_model.sv
verification/camera_config_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the camera configuration testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f project.f --top-module camera_config_tb \
    --Mdir obj_dir -o camera_config_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/camera_config_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- sccb_master/sccb_master.sv
`timescale 1ns/10ps
`default_nettype none

module sccb_master (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       wr_valid,
    output logic                       wr_ready,
    input  camera_cfg_pkg::cfg_entry_t wr_entry,
    output logic                       sioc,
    inout  wire                        siod,
    output logic                       bus_idle,
    output logic                       ack_error
);

    sccb_pkg::sccb_state_t state;

    logic [sccb_pkg::SCCB_TICK_W-1:0] tick_cnt;
    logic [sccb_pkg::SCCB_GAP_W-1:0]  gap_cnt;
    logic [2:0]                       bit_cnt;
    logic [1:0]                       byte_cnt;
    logic [7:0]                       shift_q;
    camera_cfg_pkg::cfg_entry_t       entry_q;
    logic                             siod_out;
    logic                             siod_oe;
    logic                             half_tick;
    logic                             low_start;
    logic                             bit_end;

    assign siod = siod_oe ? siod_out : 1'bz;  // Released for the ACK bit

    assign half_tick = (tick_cnt == sccb_pkg::SCCB_TICK_LAST);
    assign low_start = !sioc && (tick_cnt == '0);  // One clock after SIOC fell
    assign bit_end   = half_tick && sioc;           // SIOC about to fall

    assign bus_idle = (state == sccb_pkg::SCCB_IDLE);
    assign wr_ready = bus_idle && wr_valid;         // Pops the FIFO as a write starts

    // Half period counter, parked outside bus activity
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
        end else if (bus_idle || (state == sccb_pkg::SCCB_GAP) || half_tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // Payload, loaded when a write is accepted
    always_ff @(posedge clk) begin
        if (wr_ready) begin
            entry_q <= wr_entry;
            shift_q <= camera_cfg_pkg::CAMERA_ADDR;  // Device address goes out first
        end else if ((state == sccb_pkg::SCCB_SEND_BYTE) && bit_end) begin
            shift_q <= {shift_q[6:0], 1'b0};
        end else if ((state == sccb_pkg::SCCB_ACK) && bit_end) begin
            shift_q <= (byte_cnt == 2'd0) ? entry_q.reg_addr : entry_q.reg_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= sccb_pkg::SCCB_IDLE;
            sioc      <= 1'b1;
            siod_out  <= 1'b1;
            siod_oe   <= 1'b1;
            bit_cnt   <= 3'd0;
            byte_cnt  <= 2'd0;
            gap_cnt   <= '0;
            ack_error <= 1'b0;
        end else begin
            case (state)
                sccb_pkg::SCCB_IDLE: begin
                    if (wr_valid) begin
                        byte_cnt <= 2'd0;
                        state    <= sccb_pkg::SCCB_START;
                    end
                end

                sccb_pkg::SCCB_START: begin
                    if (half_tick) begin
                        if (siod_out) begin
                            siod_out <= 1'b0;  // Start edge under high SIOC
                        end else begin
                            sioc    <= 1'b0;
                            bit_cnt <= 3'd7;
                            state   <= sccb_pkg::SCCB_SEND_BYTE;
                        end
                    end
                end

                sccb_pkg::SCCB_SEND_BYTE: begin
                    if (low_start) begin
                        siod_oe  <= 1'b1;
                        siod_out <= shift_q[7];  // MSB first
                    end
                    if (half_tick) begin
                        sioc <= !sioc;
                        if (sioc) begin
                            if (bit_cnt == 3'd0) begin
                                state <= sccb_pkg::SCCB_ACK;
                            end else begin
                                bit_cnt <= bit_cnt - 3'd1;
                            end
                        end
                    end
                end

                sccb_pkg::SCCB_ACK: begin
                    if (low_start) begin
                        siod_oe <= 1'b0;  // Camera owns SIOD now
                    end
                    if (half_tick) begin
                        sioc <= !sioc;
                        if (!sioc && siod) begin
                            ack_error <= 1'b1;  // No ACK at the rising edge
                        end
                        if (sioc) begin
                            if (byte_cnt == sccb_pkg::SCCB_LAST_BYTE) begin
                                state <= sccb_pkg::SCCB_STOP;
                            end else begin
                                byte_cnt <= byte_cnt + 2'd1;
                                bit_cnt  <= 3'd7;
                                state    <= sccb_pkg::SCCB_SEND_BYTE;
                            end
                        end
                    end
                end

                sccb_pkg::SCCB_STOP: begin
                    if (low_start) begin
                        siod_oe  <= 1'b1;
                        siod_out <= 1'b0;  // Low so it can rise under high SIOC
                    end
                    if (half_tick) begin
                        if (!sioc) begin
                            sioc <= 1'b1;
                        end else begin
                            siod_out <= 1'b1;  // Stop edge
                            gap_cnt  <= '0;
                            state    <= sccb_pkg::SCCB_GAP;
                        end
                    end
                end

                sccb_pkg::SCCB_GAP: begin
                    if (gap_cnt == sccb_pkg::SCCB_GAP_LAST) begin
                        state <= sccb_pkg::SCCB_IDLE;
                    end else begin
                        gap_cnt <= gap_cnt + 1'b1;
                    end
                end

                default: state <= sccb_pkg::SCCB_IDLE;
            endcase
        end
    end

    // Data bits may only move while SIOC has been low for a full clock
    siod_low_change: assert property (
        @(posedge clk) disable iff (reset)
        ((state == sccb_pkg::SCCB_SEND_BYTE) && $changed(siod_out)) |-> (!sioc && !$past(sioc))
    );

    // Single-cycle pop, followed by the start condition
    wr_ready_pulse: assert property (
        @(posedge clk) disable iff (reset)
        wr_ready |=> ((state == sccb_pkg::SCCB_START) && !wr_ready)
    );

endmodule

`default_nettype wire

//--- verification/camera_config_tb.sv
`timescale 1ns/10ps
`default_nettype none

module camera_config_tb;

    localparam int          NUM_WRITES    = 22;
    localparam int          WRITE_TIMEOUT = 2000;
    localparam int unsigned GAP_MIN       = 64;
    localparam logic [4:0]  NACK_WRITE    = 5'd7;

    // Register in the high byte, data in the low byte
    localparam logic [15:0] EXPECTED [NUM_WRITES] = '{
        16'h1280, 16'h1100, 16'h3A04, 16'h1204, 16'h8C02, 16'h40D0,
        16'h141A, 16'h4FB3, 16'h50B3, 16'h5100, 16'h523D, 16'h53A7,
        16'h54E4, 16'h3DC3, 16'h1711, 16'h1875, 16'h1902, 16'h1AA2,
        16'h3280, 16'h030A, 16'h0C00, 16'h3E00
    };

    localparam bit RUN_NACK      [3] = '{1'b0, 1'b1, 1'b0};
    localparam bit RUN_MID_RESET [3] = '{1'b0, 1'b0, 1'b1};

    logic        clk;
    logic        reset;
    logic        reset_req;
    logic        sioc;
    wire         siod;
    logic        config_done;
    logic        ack_error;
    logic        nack_enable;
    logic [4:0]  nack_index;
    logic        start_seen;
    logic        stop_seen;
    logic        write_done;
    logic [7:0]  write_dev;
    logic [7:0]  write_reg;
    logic [7:0]  write_dat;
    int unsigned cycle_count = 0;
    int unsigned stop_cycle;
    bit          have_stop;
    int          writes_seen;

    clock_gen clock_gen_i (.reset_req(reset_req), .clk(clk), .reset(reset));

    camera_config_top camera_config_top_i (
        .clk         (clk),
        .reset       (reset),
        .sioc        (sioc),
        .siod        (siod),
        .config_done (config_done),
        .ack_error   (ack_error)
    );

    sccb_camera_model camera_model_i (
        .clk         (clk),
        .reset       (reset),
        .sioc        (sioc),
        .siod        (siod),
        .nack_enable (nack_enable),
        .nack_index  (nack_index),
        .start_seen  (start_seen),
        .stop_seen   (stop_seen),
        .write_done  (write_done),
        .write_dev   (write_dev),
        .write_reg   (write_reg),
        .write_dat   (write_dat)
    );

    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("error %s expected 0x%0h actual 0x%0h", name, expected, actual);
        stop_with_failure();
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        stop_with_failure();
    endtask

    task automatic check_write();
        logic [15:0] expected;
        logic        error_expected;
        assert (writes_seen < NUM_WRITES)
            else report_problem("camera model saw more writes than the table holds");
        expected       = EXPECTED[5'(writes_seen)];
        error_expected = nack_enable && (writes_seen >= int'(nack_index));  // Sticky from NACK on
        assert (write_dev == 8'h42)
            else report_mismatch($sformatf("write %0d device", writes_seen), 32'(8'h42),
                                 32'(write_dev));
        assert (write_reg == expected[15:8])
            else report_mismatch($sformatf("write %0d register", writes_seen),
                                 32'(expected[15:8]), 32'(write_reg));
        assert (write_dat == expected[7:0])
            else report_mismatch($sformatf("write %0d data", writes_seen),
                                 32'(expected[7:0]), 32'(write_dat));
        assert (ack_error == error_expected)
            else report_mismatch($sformatf("write %0d ack_error", writes_seen),
                                 32'(error_expected), 32'(ack_error));
        writes_seen = writes_seen + 1;
    endtask

    // One clock of bus monitoring, sampled mid-cycle
    task automatic sample_cycle();
        @(negedge clk);
        if (start_seen) begin
            assert (!config_done) else report_problem("start condition after config_done");
            if (have_stop) begin
                assert (cycle_count - stop_cycle >= GAP_MIN)
                    else report_mismatch("bus gap", GAP_MIN, cycle_count - stop_cycle);
            end
            have_stop = 1'b0;
        end else if (have_stop) begin
            assert (sioc) else report_problem("SIOC left high level between writes");
        end
        if (stop_seen) begin
            have_stop  = 1'b1;
            stop_cycle = cycle_count;
        end
        if (write_done) begin
            check_write();
        end else if (writes_seen < NUM_WRITES) begin
            assert (!config_done) else report_problem("config_done rose before the last write");
        end
    endtask

    task automatic apply_reset();
        int waited;
        @(posedge clk);
        reset_req <= 1'b1;
        @(posedge clk);
        reset_req <= 1'b0;
        waited = 0;
        while (!reset) begin
            @(negedge clk);
            waited++;
            if (waited > 5) report_problem("timeout waiting for reset to assert");
        end
        assert (sioc && siod && !config_done && !ack_error)
            else report_problem("outputs not at their reset values during reset");
        waited = 0;
        while (reset) begin
            @(negedge clk);
            waited++;
            if (waited > 20) report_problem("timeout waiting for reset to release");
        end
        have_stop   = 1'b0;
        writes_seen = 0;
    endtask

    task automatic collect_writes();
        int waited;
        waited = 0;
        while (writes_seen < NUM_WRITES) begin
            sample_cycle();
            waited = write_done ? 0 : waited + 1;
            if (waited > WRITE_TIMEOUT) begin
                report_problem($sformatf("timeout waiting for write %0d", writes_seen));
            end
        end
    endtask

    task automatic finish_run(input bit nack_run);
        int waited;
        waited = 0;
        while (!config_done) begin
            sample_cycle();
            waited++;
            if (waited > 500) report_problem("timeout waiting for config_done");
        end
        assert (ack_error == nack_run)
            else report_mismatch("final ack_error", 32'(nack_run), 32'(ack_error));
        repeat (2000) begin
            sample_cycle();  // Flags any start condition
            assert (config_done) else report_problem("config_done dropped after completion");
        end
    endtask

    initial begin
        int          run;
        int unsigned delay;
        reset_req   = 1'b0;
        nack_enable = 1'b0;
        nack_index  = 5'd0;
        have_stop   = 1'b0;
        stop_cycle  = 0;
        writes_seen = 0;
        void'($urandom(26));
        for (run = 0; run < 3; run++) begin
            @(posedge clk);
            nack_enable <= RUN_NACK[2'(run)];
            nack_index  <= NACK_WRITE;
            apply_reset();
            if (RUN_MID_RESET[2'(run)]) begin
                delay = 200 + ($urandom % 9000);  // Lands inside the configuration
                repeat (delay) sample_cycle();
                apply_reset();
            end
            collect_writes();
            finish_run(RUN_NACK[2'(run)]);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    input  logic reset_req,
    output logic clk,
    output logic reset
);

    int unsigned reset_cnt;

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;  // Power-on reset
        reset_cnt = RESET_CYCLES;
    end

    always #(PERIOD_NS / 2) clk = !clk;

    // A request restarts the full reset window
    always @(posedge clk) begin
        if (reset_req) begin
            reset_cnt <= RESET_CYCLES;
            reset     <= 1'b1;
        end else if (reset_cnt > 1) begin
            reset_cnt <= reset_cnt - 1;
        end else begin
            reset_cnt <= 0;
            reset     <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- verification/sccb_camera_model.sv
`timescale 1ns/10ps
`default_nettype none

module sccb_camera_model (
    input  logic       clk,
    input  logic       reset,
    input  logic       sioc,
    inout  wire        siod,
    input  logic       nack_enable,
    input  logic [4:0] nack_index,
    output logic       start_seen,
    output logic       stop_seen,
    output logic       write_done,
    output logic [7:0] write_dev,
    output logic [7:0] write_reg,
    output logic [7:0] write_dat
);

    logic       sioc_q;
    logic       siod_q;
    logic       in_frame;
    logic       ack_low;
    logic [3:0] bit_cnt;      // 8 means the ACK bit comes next
    logic [1:0] byte_cnt;
    logic [7:0] shift;
    logic [4:0] write_count;  // Index of the write on the bus

    pullup (siod);
    assign siod = ack_low ? 1'b0 : 1'bz;

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            sioc_q      <= 1'b1;
            siod_q      <= 1'b1;
            in_frame    <= 1'b0;
            ack_low     <= 1'b0;
            bit_cnt     <= 4'd0;
            byte_cnt    <= 2'd0;
            shift       <= 8'h00;
            write_count <= 5'd0;
            start_seen  <= 1'b0;
            stop_seen   <= 1'b0;
            write_done  <= 1'b0;
            write_dev   <= 8'h00;
            write_reg   <= 8'h00;
            write_dat   <= 8'h00;
        end else begin
            sioc_q     <= sioc;
            siod_q     <= siod;
            start_seen <= 1'b0;
            stop_seen  <= 1'b0;
            write_done <= 1'b0;
            if (sioc_q && sioc && siod_q && !siod) begin  // Start condition
                start_seen <= 1'b1;
                in_frame   <= 1'b1;
                bit_cnt    <= 4'd0;
                byte_cnt   <= 2'd0;
            end else if (sioc_q && sioc && !siod_q && siod) begin  // Stop condition
                stop_seen <= 1'b1;
                in_frame  <= 1'b0;
                if (in_frame && (byte_cnt == 2'd3)) begin
                    write_done  <= 1'b1;
                    write_count <= write_count + 5'd1;
                end
            end else if (in_frame && !sioc_q && sioc && (byte_cnt != 2'd3)) begin  // Rising SIOC
                if (bit_cnt != 4'd8) begin
                    shift   <= {shift[6:0], siod};
                    bit_cnt <= bit_cnt + 4'd1;
                end else begin
                    case (byte_cnt)
                        2'd0:    write_dev <= shift;
                        2'd1:    write_reg <= shift;
                        default: write_dat <= shift;
                    endcase
                    bit_cnt  <= 4'd0;
                    byte_cnt <= byte_cnt + 2'd1;
                end
            end else if (in_frame && sioc_q && !sioc) begin  // Falling SIOC
                ack_low <= (bit_cnt == 4'd8) && !(nack_enable && (nack_index == write_count));
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/camera_config_top.sv
`timescale 1ns/10ps
`default_nettype none

module camera_config_top (
    input  logic clk,
    input  logic reset,
    output logic sioc,
    inout  wire  siod,
    output logic config_done,
    output logic ack_error
);

    logic                       cfg_valid;
    logic                       cfg_ready;
    camera_cfg_pkg::cfg_entry_t cfg_entry;
    logic                       wr_valid;
    logic                       wr_ready;
    camera_cfg_pkg::cfg_entry_t wr_entry;
    logic                       fifo_empty;
    logic                       bus_idle;
    logic                       config_idle;

    assign config_idle = bus_idle && fifo_empty;  // Nothing queued, nothing on the wire

    cfg_table_sequencer cfg_table_sequencer_i (
        .clk         (clk),
        .reset       (reset),
        .cfg_valid   (cfg_valid),
        .cfg_ready   (cfg_ready),
        .cfg_entry   (cfg_entry),
        .bus_idle    (config_idle),
        .config_done (config_done)
    );

    write_fifo write_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .cfg_entry (cfg_entry),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_entry  (wr_entry),
        .empty     (fifo_empty)
    );

    sccb_master sccb_master_i (
        .clk       (clk),
        .reset     (reset),
        .wr_valid  (wr_valid),
        .wr_ready  (wr_ready),
        .wr_entry  (wr_entry),
        .sioc      (sioc),
        .siod      (siod),
        .bus_idle  (bus_idle),
        .ack_error (ack_error)
    );

endmodule

`default_nettype wire

//--- verilog/cfg_table_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module cfg_table_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    output logic                       cfg_valid,
    input  logic                       cfg_ready,
    output camera_cfg_pkg::cfg_entry_t cfg_entry,
    input  logic                       bus_idle,
    output logic                       config_done
);

    logic [camera_cfg_pkg::CFG_INDEX_W-1:0] cfg_index;
    logic [camera_cfg_pkg::CFG_INDEX_W-1:0] index_next;
    logic                                   xfer;

    assign xfer       = cfg_valid && cfg_ready;
    assign index_next = xfer ? cfg_index + 1'b1 : cfg_index;

    // Entry under the index or zero past the table end
    assign cfg_entry = (cfg_index < camera_cfg_pkg::CFG_END) ?
                       camera_cfg_pkg::CFG_TABLE[cfg_index] : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_index   <= '0;
            cfg_valid   <= 1'b0;
            config_done <= 1'b0;
        end else begin
            cfg_index <= index_next;
            cfg_valid <= (index_next < camera_cfg_pkg::CFG_END);  // Drops after the last transfer
            // All entries handed off, queue drained and bus quiet
            if (!cfg_valid && (cfg_index == camera_cfg_pkg::CFG_END) && bus_idle) begin
                config_done <= 1'b1;
            end
        end
    end

    // Offered entry must hold until the FIFO takes it
    entry_hold: assert property (
        @(posedge clk) disable iff (reset)
        (cfg_valid && !cfg_ready) |=> (cfg_valid && $stable(cfg_entry))
    );

endmodule

`default_nettype wire

//--- verilog/write_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module write_fifo (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cfg_valid,
    output logic                       cfg_ready,
    input  camera_cfg_pkg::cfg_entry_t cfg_entry,
    output logic                       wr_valid,
    input  logic                       wr_ready,
    output camera_cfg_pkg::cfg_entry_t wr_entry,
    output logic                       empty
);

    camera_cfg_pkg::cfg_entry_t mem [4];

    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    logic [2:0] count;   // 0 to 4 entries
    logic       push;
    logic       pop;

    assign cfg_ready = (count != 3'd4);
    assign wr_valid  = (count != 3'd0);
    assign empty     = (count == 3'd0);
    assign wr_entry  = mem[rd_ptr];  // Head of queue

    assign push = cfg_valid && cfg_ready;
    assign pop  = wr_ready && wr_valid;

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= cfg_entry;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= 2'd0;
            rd_ptr <= 2'd0;
            count  <= 3'd0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 2'd1;  // Wraps at four
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 2'd1;
            end
            case ({push, pop})
                2'b10:   count <= count + 3'd1;
                2'b01:   count <= count - 3'd1;
                default: count <= count;  // Idle or simultaneous push and pop
            endcase
        end
    end

    // The master must not start a write from an empty queue
    no_pop_empty: assert property (
        @(posedge clk) disable iff (reset)
        wr_ready |-> !empty
    );

    // A full queue with no pop keeps its contents
    no_push_full: assert property (
        @(posedge clk) disable iff (reset)
        (!cfg_ready && !pop) |=> (count == 3'd4)
    );

endmodule

`default_nettype wire
